//--- source/rv_pkg.sv
package rv_pkg;

    // ########################################################################
    // sizes
    // ########################################################################

    localparam int XLEN       = 32;
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    typedef logic [XLEN-1:0]               word_t;     // one data or instruction word
    typedef logic [$clog2(IMEM_WORDS)-1:0] iaddr_t;    // word index into instruction memory
    typedef logic [$clog2(DMEM_WORDS)-1:0] daddr_t;    // word index into data memory
    typedef logic [4:0]                    reg_idx_t;  // register number x0 to x31

    // ########################################################################
    // instruction encodings
    // ########################################################################

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic [1:0] {
        REG  = 2'd0,   // rs1 value
        PC   = 2'd1,   // auipc adds to the pc
        ZERO = 2'd2    // lui passes the immediate through
    } opa_sel_e;

    typedef enum logic [1:0] {
        ALU      = 2'd0,
        MEM      = 2'd1,
        PC_PLUS4 = 2'd2   // link value of jal
    } wb_sel_e;

    // ########################################################################
    // bundles between blocks
    // ########################################################################

    typedef struct packed {
        logic     reg_write;
        logic     mem_write;
        logic     branch;
        logic     jump;
        logic     alu_src_imm;  // second operand is the immediate
        opa_sel_e opa_sel;
        wb_sel_e  wb_sel;
        alu_op_e  alu_op;
        word_t    imm;
    } ctrl_t;

    typedef struct packed {
        logic   valid;  // store commits at the next rising edge
        daddr_t addr;
        word_t  data;
    } store_t;

endpackage

//--- source/rv_decoder.sv
`timescale 1ns/10ps

module rv_decoder (
    input  rv_pkg::word_t instr,
    output rv_pkg::ctrl_t ctrl
);
    import rv_pkg::*;

    opcode_e opcode;
    logic [2:0] funct3;
    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_j;
    word_t imm_u;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];

    // ########################################################################
    // immediates, all sign extended from bit 31 except the u form
    // ########################################################################

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};

    // maps funct3 to an alu operation; bit 30 picks sub and sra
    function automatic alu_op_e arith_op(input logic [2:0] f3,
                                         input logic sub_sel,
                                         input logic sra_sel);
        alu_op_e op;
        case (f3)
            3'b000:  op = sub_sel ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = sra_sel ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    // ########################################################################
    // main control
    // ########################################################################

    always_comb begin
        ctrl         = '0;          // unknown opcodes fall out as a no-op
        ctrl.opa_sel = REG;
        ctrl.wb_sel  = ALU;
        ctrl.alu_op  = ALU_ADD;     // address and upper immediate forms all add
        ctrl.imm     = imm_i;
        case (opcode)
            OP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = arith_op(funct3, instr[30], instr[30]);
            end
            OP_IMM: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = arith_op(funct3, 1'b0, instr[30]);  // no subi in the isa
            end
            LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.wb_sel      = MEM;
            end
            STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.imm         = imm_s;
            end
            BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;   // equality shows up on the zero flag
                ctrl.imm    = imm_b;
            end
            JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.wb_sel    = PC_PLUS4;
                ctrl.imm       = imm_j;
            end
            LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.opa_sel     = ZERO;
                ctrl.imm         = imm_u;
            end
            AUIPC: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.opa_sel     = PC;
                ctrl.imm         = imm_u;
            end
            default: begin
                ctrl.reg_write = 1'b0;
            end
        endcase
    end

endmodule

//--- source/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
    input                    CLK,
    input                    RESET_N,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input                    wr_en,
    input  rv_pkg::word_t    wr_data,
    output rv_pkg::word_t    rd1,
    output rv_pkg::word_t    rd2
);
    import rv_pkg::*;

    word_t regs [1:31];  // x0 has no storage

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && rd != '0) begin
            regs[rd] <= wr_data;  // writes to x0 are dropped here
        end
    end

    // reads are combinational so the write-back lands in the same cycle
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- source/rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e op,
    output rv_pkg::word_t   result,
    output logic            zero
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // only the low five bits shift a 32-bit word

    always_comb begin
        case (op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
            ALU_SLTU: result = (a < b) ? word_t'(1) : '0;
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = word_t'($signed(a) >>> shamt);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // beq and bne look only at this flag
    assign zero = (result == '0);

endmodule

//--- source/rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input                   CLK,
    input                   RESET_N,
    input                   run,
    output rv_pkg::iaddr_t  fetch_addr,
    input  rv_pkg::word_t   instr,
    output rv_pkg::daddr_t  data_addr,
    input  rv_pkg::word_t   data_rd,
    output rv_pkg::store_t  store
);
    import rv_pkg::*;

    ctrl_t    ctrl;
    word_t    pc;
    word_t    pc_plus4;
    word_t    pc_target;
    word_t    next_pc;
    word_t    rd1;
    word_t    rd2;
    word_t    opa;
    word_t    opb;
    word_t    alu_result;
    word_t    wb_data;
    logic     zero;
    logic     take_branch;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    rv_decoder decoder_i (.instr(instr), .ctrl(ctrl));

    rv_regfile regfile_i (
        .CLK(CLK), .RESET_N(RESET_N),
        .rs1(rs1), .rs2(rs2), .rd(rd),
        .wr_en(ctrl.reg_write && run),   // nothing retires while halted
        .wr_data(wb_data),
        .rd1(rd1), .rd2(rd2)
    );

    // ########################################################################
    // operands and alu
    // ########################################################################

    always_comb begin
        case (ctrl.opa_sel)
            PC:      opa = pc;
            ZERO:    opa = '0;
            default: opa = rd1;
        endcase
    end

    assign opb = ctrl.alu_src_imm ? ctrl.imm : rd2;

    rv_alu alu_i (.a(opa), .b(opb), .op(ctrl.alu_op), .result(alu_result), .zero(zero));

    always_comb begin
        case (ctrl.wb_sel)
            MEM:      wb_data = data_rd;
            PC_PLUS4: wb_data = pc_plus4;
            default:  wb_data = alu_result;
        endcase
    end

    // ########################################################################
    // next pc, funct3 bit 0 separates bne from beq
    // ########################################################################

    assign pc_plus4    = pc + word_t'(4);
    assign pc_target   = pc + ctrl.imm;
    assign take_branch = ctrl.branch && (zero != instr[12]);
    assign next_pc     = (ctrl.jump || take_branch) ? pc_target : pc_plus4;

    always_ff @(posedge CLK or negedge RESET_N) begin
        if (!RESET_N) begin
            pc <= '0;
        end else if (run) begin
            pc <= next_pc;
        end
    end

    assign fetch_addr = pc[$bits(iaddr_t)+1:2];
    assign data_addr  = alu_result[$bits(daddr_t)+1:2];  // low address bits are ignored

    assign store.valid = ctrl.mem_write && run;
    assign store.addr  = data_addr;
    assign store.data  = rd2;

endmodule

//--- source/rv_instr_ram.sv
`timescale 1ns/10ps

module rv_instr_ram (
    input                  CLK,
    input  rv_pkg::iaddr_t rd_addr,
    output rv_pkg::word_t  rd_data,
    input                  wr_en,
    input  rv_pkg::iaddr_t wr_addr,
    input  rv_pkg::word_t  wr_data
);
    import rv_pkg::*;

    word_t mem [IMEM_WORDS];

    // ########################################################################
    // fetch side
    // ########################################################################

    assign rd_data = mem[rd_addr];  // instruction is ready in the same cycle

    // ########################################################################
    // program load side
    // ########################################################################

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

//--- source/rv_data_ram.sv
`timescale 1ns/10ps

module rv_data_ram (
    input                  CLK,
    input  rv_pkg::daddr_t addr,
    output rv_pkg::word_t  rd_data,
    input  rv_pkg::store_t store
);
    import rv_pkg::*;

    word_t mem [DMEM_WORDS];

    // lw sees the word in the cycle it is fetched
    assign rd_data = mem[addr];

    // ########################################################################
    // write port, driven by sw
    // ########################################################################

    always_ff @(posedge CLK) begin
        if (store.valid) begin
            mem[store.addr] <= store.data;
        end
    end

endmodule

//--- source/rv_system.sv
`timescale 1ns/10ps

module rv_system (
    input                  CLK,
    input                  RESET_N,
    input                  run,
    input                  load_en,
    input  rv_pkg::iaddr_t load_addr,
    input  rv_pkg::word_t  load_data,
    output rv_pkg::store_t store
);
    import rv_pkg::*;

    iaddr_t fetch_addr;
    word_t  instr;
    daddr_t data_addr;
    word_t  data_rd;

    rv_core core_i (
        .CLK(CLK),
        .RESET_N(RESET_N),
        .run(run),
        .fetch_addr(fetch_addr),
        .instr(instr),
        .data_addr(data_addr),
        .data_rd(data_rd),
        .store(store)          // same bundle feeds the data ram
    );

    rv_instr_ram instr_ram_i (
        .CLK(CLK),
        .rd_addr(fetch_addr),
        .rd_data(instr),
        .wr_en(load_en),       // programs are loaded while run is low
        .wr_addr(load_addr),
        .wr_data(load_data)
    );

    rv_data_ram data_ram_i (
        .CLK(CLK),
        .addr(data_addr),
        .rd_data(data_rd),
        .store(store)
    );

endmodule

//--- sim/rv_system_sva.sv
`timescale 1ns/10ps

module rv_system_sva (
    input                    CLK,
    input                    RESET_N,
    input                    run,
    input  rv_pkg::word_t    pc,
    input  rv_pkg::store_t   store,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::word_t    rd1,
    input  rv_pkg::word_t    rd2
);
    import rv_pkg::*;

    // fetch drops the two low bits so they have to stay clear
    pc_aligned: assert property (@(posedge CLK) disable iff (!RESET_N)
        pc[1:0] == 2'b00)
        else $error("pc is not word aligned: %h", pc);

    pc_holds: assert property (@(posedge CLK) disable iff (!RESET_N)
        !run |=> $stable(pc))
        else $error("pc moved while run was low");

    no_store_halted: assert property (@(posedge CLK) disable iff (!RESET_N)
        !run |-> !store.valid)
        else $error("store valid while run was low");

    x0_reads_zero: assert property (@(posedge CLK) disable iff (!RESET_N)
        ((rs1 != '0) || (rd1 == '0)) && ((rs2 != '0) || (rd2 == '0)))
        else $error("a read of x0 returned a nonzero value");

endmodule

bind rv_core rv_system_sva sva_i (
    .CLK(CLK), .RESET_N(RESET_N), .run(run), .pc(pc), .store(store),
    .rs1(rs1), .rs2(rs2), .rd1(rd1), .rd2(rd2)
);

//--- sim/rv_system_tb.sv
`timescale 1ns/10ps

module rv_system_tb;
    import rv_pkg::*;

    logic   CLK;
    logic   RESET_N;
    logic   run;
    logic   load_en;
    iaddr_t load_addr;
    word_t  load_data;
    store_t store;

    word_t       prog[$];                  // program image of the current test
    daddr_t      exp_addr[$];
    word_t       exp_data[$];
    int          slot;                     // next free result word in data memory
    time         time_budget = 64'd600;    // grows with every program that is run
    logic [31:0] lfsr_state  = 32'd80608;

    rv_system dut_i (
        .CLK(CLK), .RESET_N(RESET_N), .run(run), .load_en(load_en),
        .load_addr(load_addr), .load_data(load_data), .store(store)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // ########################################################################
    // random bits and instruction encoders
    // ########################################################################

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];  // taps 32 22 2 1
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [11:0] random_imm12();
        logic [11:0] v;
        v = '0;
        for (int i = 0; i < 12; i++) begin
            v = {v[10:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic word_t sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};  // always sw
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                    input opcode_e opc);
        return {imm, rd, opc};
    endfunction

    // ########################################################################
    // checks and program handling
    // ########################################################################

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(input string test, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("Error %s: expected %h, actual %h", test, expected, actual));
        end
    endtask

    task automatic check_addr(input string test, input daddr_t expected, input daddr_t actual);
        if (actual !== expected) begin
            fail_now($sformatf("Error %s: expected addr %h, actual addr %h", test, expected,
                               actual));
        end
    endtask

    task automatic new_program();
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
        slot = 0;
    endtask

    task automatic expect_store(input daddr_t addr, input word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // the instruction writes rd and a sw copies rd to the next free word
    task automatic emit_result(input word_t instr, input reg_idx_t rd, input word_t expected);
        prog.push_back(instr);
        prog.push_back(enc_s(12'(slot * 4), rd, 5'd0));
        expect_store(daddr_t'(slot), expected);
        slot++;
    endtask

    task automatic run_program(input string test, input int idle_cycles);
        word_t  got_data[$];
        daddr_t got_addr[$];
        int     cycles;
        prog.push_back(enc_j(21'd0, 5'd0));              // jal to itself parks the core
        time_budget += 64'(prog.size() * 16);
        run     = 1'b0;
        RESET_N = 1'b0;
        repeat (3) @(posedge CLK);
        #1 RESET_N = 1'b1;
        foreach (prog[i]) begin
            load_en   = 1'b1;
            load_addr = iaddr_t'(i);
            load_data = prog[i];
            @(posedge CLK);
            #1;
        end
        load_en = 1'b0;
        repeat (idle_cycles) begin
            @(negedge CLK);
            if (store.valid) begin
                fail_now($sformatf("%s: a store appeared while run was low", test));
            end
        end
        @(posedge CLK);
        #1 run = 1'b1;
        cycles = 0;
        while (got_addr.size() < exp_addr.size()) begin
            @(negedge CLK);                               // store is settled mid cycle
            if (store.valid) begin
                got_addr.push_back(store.addr);
                got_data.push_back(store.data);
            end
            cycles++;
            if (got_addr.size() < exp_addr.size() && cycles > prog.size() + 8) begin
                fail_now($sformatf("%s: only %0d of %0d stores arrived", test,
                                   got_addr.size(), exp_addr.size()));
            end
        end
        repeat (4) begin
            @(negedge CLK);
            if (store.valid) begin
                fail_now($sformatf("%s: an extra store appeared after the last one", test));
            end
        end
        @(posedge CLK);
        #1 run = 1'b0;
        foreach (exp_addr[i]) begin
            check_addr($sformatf("%s store %0d", test, i), exp_addr[i], got_addr[i]);
            check_word($sformatf("%s store %0d", test, i), exp_data[i], got_data[i]);
        end
    endtask

    // ########################################################################
    // directed tests
    // ########################################################################

    task automatic test_reset_start();
        new_program();
        prog.push_back(enc_s(12'd12, 5'd0, 5'd0));          // sw waits at pc 0 while run is low
        prog.push_back(enc_i(12'd123, 5'd0, 3'b000, 5'd1, OP_IMM));
        prog.push_back(enc_i(12'(-7), 5'd0, 3'b000, 5'd2, OP_IMM));
        prog.push_back(enc_s(12'd4, 5'd1, 5'd0));
        prog.push_back(enc_s(12'd8, 5'd2, 5'd0));
        expect_store(8'd3, 32'd0);                        // only a start at pc 0 stores here first
        expect_store(8'd1, 32'd123);
        expect_store(8'd2, sext12(12'(-7)));
        run_program("reset_start", 6);
    endtask

    task automatic test_r_type();
        word_t a;
        word_t b;
        a = sext12(12'h9A7);
        b = 32'd19;
        new_program();
        prog.push_back(enc_i(12'h9A7, 5'd0, 3'b000, 5'd1, OP_IMM));
        prog.push_back(enc_i(12'd19, 5'd0, 3'b000, 5'd2, OP_IMM));
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, a + b);
        emit_result(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3), 5'd3, a - b);
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd3), 5'd3, a & b);
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd3), 5'd3, a | b);
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd3), 5'd3, a ^ b);
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd3), 5'd3, a << b[4:0]);
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd3), 5'd3, a >> b[4:0]);
        emit_result(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd3), 5'd3,
                    word_t'($signed(a) >>> b[4:0]));
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd3), 5'd3,
                    {31'd0, $signed(a) < $signed(b)});
        emit_result(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd3), 5'd3, {31'd0, a < b});
        run_program("r_type", 1);
    endtask

    task automatic test_immediates();
        word_t a;
        a = sext12(12'(-100));
        new_program();
        emit_result(enc_i(12'(-100), 5'd0, 3'b000, 5'd1, OP_IMM), 5'd1, a);
        emit_result(enc_i(12'h800, 5'd1, 3'b000, 5'd2, OP_IMM), 5'd2, a - 32'd2048);
        emit_result(enc_i(12'h0F0, 5'd1, 3'b100, 5'd3, OP_IMM), 5'd3, a ^ 32'h0F0);
        emit_result(enc_i(12'h123, 5'd1, 3'b110, 5'd4, OP_IMM), 5'd4, a | 32'h123);
        emit_result(enc_i(12'h7FF, 5'd1, 3'b111, 5'd5, OP_IMM), 5'd5, a & 32'h7FF);
        emit_result(enc_i(12'h005, 5'd1, 3'b001, 5'd6, OP_IMM), 5'd6, a << 5);
        emit_result(enc_i(12'h007, 5'd1, 3'b101, 5'd7, OP_IMM), 5'd7, a >> 7);
        emit_result(enc_i(12'h407, 5'd1, 3'b101, 5'd8, OP_IMM), 5'd8,
                    word_t'($signed(a) >>> 7));
        emit_result(enc_i(12'(-99), 5'd1, 3'b010, 5'd9, OP_IMM), 5'd9, 32'd1);   // -100 < -99
        emit_result(enc_i(12'd5, 5'd1, 3'b011, 5'd10, OP_IMM), 5'd10, 32'd0);   // a is huge
        emit_result(enc_u(20'hABCDE, 5'd11, LUI), 5'd11, {20'hABCDE, 12'h000});
        emit_result(enc_u(20'h12345, 5'd12, AUIPC), 5'd12,
                    word_t'(prog.size() * 4) + {20'h12345, 12'h000});
        run_program("immediates", 1);
    endtask

    task automatic test_mem_round_trip();
        word_t value;
        value = {20'hDEADB, 12'h000} + 32'h7EF;
        new_program();
        prog.push_back(enc_u(20'hDEADB, 5'd1, LUI));
        prog.push_back(enc_i(12'h7EF, 5'd1, 3'b000, 5'd1, OP_IMM));
        prog.push_back(enc_i(12'h100, 5'd0, 3'b000, 5'd3, OP_IMM));
        prog.push_back(enc_s(12'h010, 5'd1, 5'd3));
        prog.push_back(enc_i(12'h010, 5'd3, 3'b010, 5'd2, LOAD));
        prog.push_back(enc_s(12'(-4), 5'd2, 5'd3));
        expect_store(daddr_t'((32'h100 + 32'h10) >> 2), value);
        expect_store(daddr_t'((32'h100 - 32'd4) >> 2), value);
        run_program("mem_round_trip", 1);
    endtask

    task automatic test_control_flow();
        new_program();
        prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));   // byte 0
        prog.push_back(enc_i(12'd5, 5'd0, 3'b000, 5'd2, OP_IMM));   // byte 4
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b000));           // beq taken to 16
        prog.push_back(enc_s(12'd0, 5'd1, 5'd0));
        prog.push_back(enc_s(12'd4, 5'd2, 5'd0));                   // byte 16
        prog.push_back(enc_b(13'd8, 5'd2, 5'd1, 3'b001));           // bne falls through
        prog.push_back(enc_s(12'd8, 5'd1, 5'd0));
        prog.push_back(enc_b(13'd8, 5'd0, 5'd1, 3'b001));           // bne taken to 36
        prog.push_back(enc_s(12'd12, 5'd0, 5'd0));
        prog.push_back(enc_j(21'd8, 5'd4));                         // jal at 36 to 44
        prog.push_back(enc_s(12'd16, 5'd0, 5'd0));
        prog.push_back(enc_s(12'd20, 5'd4, 5'd0));
        expect_store(8'd1, 32'd5);
        expect_store(8'd2, 32'd5);
        expect_store(8'd5, 32'd36 + 32'd4);                         // link is jal pc + 4
        run_program("control_flow", 1);
    endtask

    task automatic test_random_arith();
        logic [11:0] imm_a;
        logic [11:0] imm_b;
        logic [1:0]  choice;
        logic [6:0]  f7;
        logic [2:0]  f3;
        word_t       a;
        word_t       b;
        word_t       expected;
        new_program();
        for (int n = 0; n < 20; n++) begin
            imm_a     = random_imm12();
            imm_b     = random_imm12();
            choice[1] = lfsr_bit();
            choice[0] = lfsr_bit();
            a         = sext12(imm_a);
            b         = sext12(imm_b);
            f7        = 7'h00;
            case (choice)
                2'd0: begin
                    f3       = 3'b000;
                    expected = a + b;
                end
                2'd1: begin
                    f7       = 7'h20;
                    f3       = 3'b000;
                    expected = a - b;
                end
                2'd2: begin
                    f3       = 3'b100;
                    expected = a ^ b;
                end
                default: begin
                    f3       = 3'b011;
                    expected = {31'd0, a < b};
                end
            endcase
            prog.push_back(enc_i(imm_a, 5'd0, 3'b000, 5'd1, OP_IMM));
            prog.push_back(enc_i(imm_b, 5'd0, 3'b000, 5'd2, OP_IMM));
            emit_result(enc_r(f7, 5'd2, 5'd1, f3, 5'd3), 5'd3, expected);
        end
        run_program("random_arith", 1);
    endtask

    initial begin
        RESET_N   = 1'b0;
        run       = 1'b0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        @(posedge CLK);
        #1;
        test_reset_start();
        test_r_type();
        test_immediates();
        test_mem_round_trip();
        test_control_flow();
        test_random_arith();
        $display("Verification passed");
        $finish;
    end

    initial begin
        while ($time <= time_budget) begin
            #4;
        end
        $display("watchdog expired after %0t ns without the tests finishing", time_budget);
        $display("Verification failed");
        $fatal(1, "simulation timed out");
    end

endmodule

//--- rv_system.f
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_alu.sv
source/rv_core.sv
source/rv_instr_ram.sv
source/rv_data_ram.sv
source/rv_system.sv
sim/rv_system_sva.sv
sim/rv_system_tb.sv

//--- Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := rv_system_tb
FILELIST  := rv_system.f
BUILD_DIR := obj_dir
PASS_TEXT := Verification passed

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
